/* source/blast_pkg.sv */
`default_nettype none

package blast_pkg;

   // sizes
   localparam int WORD_BITS      = 64;
   localparam int HALF_BITS      = WORD_BITS / 2;
   localparam int ADDR_BITS      = 14;
   localparam int CHAR_BITS      = 3;
   localparam int CHARS_PER_WORD = 21;
   localparam int WORD_CNT_BITS  = 5;
   localparam int QUERY_WORDS    = 2;
   localparam int QIDX_BITS      = 2;
   localparam int QUERY_CHARS    = 42;
   localparam int SEED_LEN       = 4;
   localparam int SEED_POSITIONS = QUERY_CHARS - SEED_LEN + 1;

   // memory map, in words
   localparam logic [ADDR_BITS-1:0] QUERY_BASE   = 14'd0;
   localparam logic [ADDR_BITS-1:0] SUBJECT_BASE = 14'd16;
   localparam logic [ADDR_BITS-1:0] HIT_BASE     = 14'd1024;

   // application command codes
   localparam logic [7:0] CMD_READ_QUERY   = 8'haa;
   localparam logic [7:0] CMD_READ_SUBJECT = 8'hbb;

   // count is the length in characters when read, the hit count when written
   typedef struct packed {
      logic [HALF_BITS-1:0] subject_id;
      logic [HALF_BITS-1:0] count;
   } header_t;

   typedef struct packed {
      logic [HALF_BITS-1:0] subject_pos;
      logic [HALF_BITS-1:0] query_pos;
   } hit_t;

   typedef union packed {
      logic [WORD_BITS-1:0] raw;
      header_t              header;
      hit_t                 hit;
   } mem_word_u;

   typedef struct packed {
      logic [ADDR_BITS-1:0] addr;
      logic                 write;
      mem_word_u            wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic [WORD_BITS-1:0]     data;
      logic [WORD_CNT_BITS-1:0] count;
   } char_word_t;

   typedef struct packed {
      logic                 valid;
      logic [CHAR_BITS-1:0] ch;
   } subject_char_t;

   typedef struct packed {
      logic                 valid;
      logic [QIDX_BITS-1:0] index;
      logic [WORD_BITS-1:0] data;
   } query_load_t;

   // element 0 is the first query character
   typedef logic [QUERY_CHARS-1:0][CHAR_BITS-1:0] query_chars_t;

endpackage

`default_nettype wire

/* source/query_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module query_buffer import blast_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  query_load_t  query_load,
   output query_chars_t query_chars
);

   // word n fills characters 21n to 21n+20, char 0 in the low bits
   always_ff @(posedge clk) begin
      if (reset) begin
         query_chars <= '0;
      end else if (query_load.valid) begin
         for (int i = 0; i < CHARS_PER_WORD; i++) begin
            query_chars[query_load.index * CHARS_PER_WORD + i] <=
               query_load.data[i*CHAR_BITS +: CHAR_BITS];
         end
      end
   end

   a_index_range: assert property (@(posedge clk) disable iff (reset)
      query_load.valid |-> query_load.index < QUERY_WORDS);

endmodule

`default_nettype wire

/* source/subject_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module subject_shifter import blast_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  char_word_t    subject_word,
   input  logic          subject_load,
   input  logic          hold,
   output subject_char_t subject_char,
   output logic          shifter_empty
);

   logic [WORD_BITS-1:0]     word_q;
   logic [WORD_CNT_BITS-1:0] count_q;

   assign shifter_empty = (count_q == '0);

   // lowest character of the held word is always the next one out
   assign subject_char.valid = !shifter_empty && !hold;
   assign subject_char.ch    = word_q[CHAR_BITS-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
      end else if (subject_load) begin
         count_q <= subject_word.count;
      end else if (subject_char.valid) begin
         count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (subject_load) begin
         word_q <= subject_word.data;
      end else if (subject_char.valid) begin
         word_q <= word_q >> CHAR_BITS;
      end
   end

   // sequencer only fetches once every character has left
   a_load_when_empty: assert property (@(posedge clk) disable iff (reset)
      subject_load |-> shifter_empty);

endmodule

`default_nettype wire

/* source/seed_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module seed_matcher import blast_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  query_chars_t  query_chars,
   input  subject_char_t subject_char,
   input  logic          subject_start,
   input  logic          hit_taken,
   output logic          hit_valid,
   output hit_t          hit,
   output logic          hold
);

   // element 0 holds the oldest character of the window
   logic [SEED_LEN-1:0][CHAR_BITS-1:0] window;
   logic [SEED_LEN-1:0][CHAR_BITS-1:0] win_next;
   logic [2:0]                         fill_q;
   logic [HALF_BITS-1:0]               start_q;
   logic [HALF_BITS-1:0]               next_start;
   logic [HALF_BITS-1:0]               match_pos;
   logic                               match_any;
   logic                               full_next;
   logic                               accept;

   assign accept     = subject_char.valid;
   assign hold       = hit_valid;
   assign full_next  = (fill_q >= SEED_LEN - 1);
   assign next_start = (fill_q == SEED_LEN) ? start_q + 1'b1 : start_q;

   always_comb begin
      win_next[SEED_LEN-1] = subject_char.ch;
      for (int i = 0; i < SEED_LEN - 1; i++) begin
         win_next[i] = window[i+1];
      end
      match_any = 1'b0;
      match_pos = '0;
      // walk downward so the lowest matching position wins
      for (int j = SEED_POSITIONS - 1; j >= 0; j--) begin
         if (query_chars[j +: SEED_LEN] == win_next) begin
            match_any = 1'b1;
            match_pos = HALF_BITS'(j);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fill_q    <= '0;
         start_q   <= '0;
         hit_valid <= 1'b0;
      end else begin
         if (subject_start) begin
            fill_q  <= '0;
            start_q <= '0;
         end else if (accept) begin
            start_q <= next_start;
            if (fill_q != SEED_LEN) begin
               fill_q <= fill_q + 1'b1;
            end
            if (full_next && match_any) begin
               hit_valid <= 1'b1;
            end
         end
         if (hit_taken) begin
            hit_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (subject_start) begin
         window <= '0;
      end else if (accept) begin
         window <= win_next;
      end
      if (accept && full_next && match_any) begin
         hit.subject_pos <= next_start;
         hit.query_pos   <= match_pos;
      end
   end

   // hold must stop the shifter before a second hit could overwrite the first
   a_no_accept_pending: assert property (@(posedge clk) disable iff (reset)
      hit_valid |-> !subject_char.valid);

endmodule

`default_nettype wire

/* source/blast_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module blast_sequencer import blast_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        app_ready,
   input  logic [7:0]  app_code,
   input  logic        mem_ack,
   input  mem_word_u   mem_rdata,
   input  logic        shifter_empty,
   input  logic        hit_valid,
   input  hit_t        hit,
   output logic        busy,
   output logic        mem_req,
   output mem_cmd_t    mem_cmd,
   output query_load_t query_load,
   output char_word_t  subject_word,
   output logic        subject_load,
   output logic        subject_start,
   output logic        hit_taken
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_QUERY,
      ST_HEADER,
      ST_WORD,
      ST_HIT,
      ST_SUMMARY
   } state_t;

   state_t                   state;
   state_t                   next_state;
   logic [ADDR_BITS-1:0]     query_addr;
   logic [ADDR_BITS-1:0]     subject_addr;
   logic [ADDR_BITS-1:0]     hit_addr;
   logic [ADDR_BITS-1:0]     query_offset;
   logic [HALF_BITS-1:0]     subject_id;
   logic [HALF_BITS-1:0]     remaining;
   logic [HALF_BITS-1:0]     hit_count;
   logic [WORD_CNT_BITS-1:0] chunk;
   logic                     done_access;
   logic                     port_free;
   logic                     issue;
   mem_cmd_t                 next_cmd;

   // an access ends on the edge where ack is seen with req still high
   assign done_access = mem_req && mem_ack;
   // previous handshake fully returned to zero
   assign port_free   = !mem_req && !mem_ack;
   assign busy        = (state != ST_IDLE);

   assign query_offset = query_addr - QUERY_BASE;
   assign chunk = (remaining >= CHARS_PER_WORD) ? WORD_CNT_BITS'(CHARS_PER_WORD)
                                                : remaining[WORD_CNT_BITS-1:0];

   assign query_load.valid   = (state == ST_QUERY) && done_access;
   assign query_load.index   = query_offset[QIDX_BITS-1:0];
   assign query_load.data    = mem_rdata.raw;
   assign subject_word.data  = mem_rdata.raw;
   assign subject_word.count = chunk;
   assign subject_load       = (state == ST_WORD) && done_access;
   assign subject_start      = (state == ST_HEADER) && done_access;
   assign hit_taken          = (state == ST_HIT) && done_access;

   always_comb begin
      next_state = state;
      issue      = 1'b0;
      next_cmd   = '0;
      case (state)
         ST_IDLE: begin
            if (app_ready && app_code == CMD_READ_QUERY) begin
               next_state = ST_QUERY;
            end else if (app_ready && app_code == CMD_READ_SUBJECT) begin
               next_state = ST_HEADER;
            end
         end
         ST_QUERY: begin
            issue         = port_free;
            next_cmd.addr = query_addr;
            if (done_access && query_offset == QUERY_WORDS - 1) begin
               next_state = ST_IDLE;
            end
         end
         ST_HEADER: begin
            issue         = port_free;
            next_cmd.addr = subject_addr;
            if (done_access) begin
               next_state = ST_WORD;
            end
         end
         ST_WORD: begin
            // pending hit goes out first so the shifter can resume
            if (port_free && hit_valid) begin
               issue              = 1'b1;
               next_state         = ST_HIT;
               next_cmd.addr      = hit_addr;
               next_cmd.write     = 1'b1;
               next_cmd.wdata.hit = hit;
            end else if (port_free && shifter_empty && remaining != '0) begin
               issue         = 1'b1;
               next_cmd.addr = subject_addr;
            end else if (port_free && shifter_empty) begin
               issue                           = 1'b1;
               next_state                      = ST_SUMMARY;
               next_cmd.addr                   = HIT_BASE;
               next_cmd.write                  = 1'b1;
               next_cmd.wdata.header.subject_id = subject_id;
               next_cmd.wdata.header.count     = hit_count;
            end
         end
         ST_HIT: begin
            if (done_access) begin
               next_state = ST_WORD;
            end
         end
         ST_SUMMARY: begin
            if (done_access) begin
               next_state = ST_IDLE;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ST_IDLE;
         mem_req      <= 1'b0;
         query_addr   <= QUERY_BASE;
         subject_addr <= SUBJECT_BASE;
         hit_addr     <= HIT_BASE + 1'b1;
         remaining    <= '0;
         hit_count    <= '0;
      end else begin
         state <= next_state;
         if (issue) begin
            mem_req <= 1'b1;
         end else if (done_access) begin
            mem_req <= 1'b0;
         end
         // counters restart for every command
         if (state == ST_IDLE) begin
            query_addr   <= QUERY_BASE;
            subject_addr <= SUBJECT_BASE;
            hit_addr     <= HIT_BASE + 1'b1;
            hit_count    <= '0;
         end
         if (query_load.valid) begin
            query_addr <= query_addr + 1'b1;
         end
         if (subject_start) begin
            remaining    <= mem_rdata.header.count;
            subject_addr <= subject_addr + 1'b1;
         end
         if (subject_load) begin
            remaining    <= remaining - chunk;
            subject_addr <= subject_addr + 1'b1;
         end
         if (hit_taken) begin
            hit_addr  <= hit_addr + 1'b1;
            hit_count <= hit_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         mem_cmd <= next_cmd;
      end
      if (subject_start) begin
         subject_id <= mem_rdata.header.subject_id;
      end
   end

   // request stays put until the memory answers
   a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
      mem_req && !mem_ack |=> $stable(mem_cmd));

endmodule

`default_nettype wire

/* source/blast_top.sv */
`timescale 1ns/1ps
`default_nettype none

module blast_top import blast_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       app_ready,
   input  logic [7:0] app_code,
   output logic       busy,
   output logic       mem_req,
   output mem_cmd_t   mem_cmd,
   input  logic       mem_ack,
   input  mem_word_u  mem_rdata
);

   query_load_t   query_load;
   query_chars_t  query_chars;
   char_word_t    subject_word;
   subject_char_t subject_char;
   hit_t          hit;
   logic          subject_load;
   logic          subject_start;
   logic          shifter_empty;
   logic          hit_valid;
   logic          hit_taken;
   logic          hold;

   blast_sequencer u_sequencer (
      .clk           (clk),
      .reset         (reset),
      .app_ready     (app_ready),
      .app_code      (app_code),
      .mem_ack       (mem_ack),
      .mem_rdata     (mem_rdata),
      .shifter_empty (shifter_empty),
      .hit_valid     (hit_valid),
      .hit           (hit),
      .busy          (busy),
      .mem_req       (mem_req),
      .mem_cmd       (mem_cmd),
      .query_load    (query_load),
      .subject_word  (subject_word),
      .subject_load  (subject_load),
      .subject_start (subject_start),
      .hit_taken     (hit_taken)
   );

   query_buffer u_query (
      .clk         (clk),
      .reset       (reset),
      .query_load  (query_load),
      .query_chars (query_chars)
   );

   subject_shifter u_subject (
      .clk           (clk),
      .reset         (reset),
      .subject_word  (subject_word),
      .subject_load  (subject_load),
      .hold          (hold),
      .subject_char  (subject_char),
      .shifter_empty (shifter_empty)
   );

   seed_matcher u_matcher (
      .clk           (clk),
      .reset         (reset),
      .query_chars   (query_chars),
      .subject_char  (subject_char),
      .subject_start (subject_start),
      .hit_taken     (hit_taken),
      .hit_valid     (hit_valid),
      .hit           (hit),
      .hold          (hold)
   );

endmodule

`default_nettype wire

/* bench/blast_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

module blast_memory_model import blast_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      mem_req,
   input  mem_cmd_t  mem_cmd,
   output logic      mem_ack,
   output mem_word_u mem_rdata
);

   localparam int MEM_WORDS = 1 << ADDR_BITS;
   localparam int LOG_DEPTH = 8192;

   logic [WORD_BITS-1:0] mem [0:MEM_WORDS-1];

   // every completed access in order, reads included
   logic [ADDR_BITS-1:0] log_addr  [0:LOG_DEPTH-1];
   logic                 log_write [0:LOG_DEPTH-1];
   mem_word_u            log_data  [0:LOG_DEPTH-1];
   int                   log_count;

   integer seed;
   int     delay;
   logic   pending;

   initial begin
      seed      = 85;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      pending   = 1'b0;
      delay     = 0;
      log_count = 0;
      // background pattern, different for every address
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {16'ha5c3, 16'(i), 16'h3c5a, ~16'(i)};
      end
   end

   // outputs change on the falling edge only
   always @(negedge clk) begin
      if (reset) begin
         mem_ack = 1'b0;
         pending = 1'b0;
      end else if (mem_ack) begin
         // return to zero once req is gone
         if (!mem_req) begin
            mem_ack = 1'b0;
         end
      end else if (mem_req) begin
         if (!pending) begin
            pending = 1'b1;
            delay   = {$random(seed)} % 5;
         end
         if (delay == 0) begin
            pending = 1'b0;
            if (mem_cmd.write) begin
               mem[mem_cmd.addr]   = mem_cmd.wdata.raw;
               log_data[log_count] = mem_cmd.wdata;
            end else begin
               mem_rdata.raw       = mem[mem_cmd.addr];
               log_data[log_count] = mem_rdata;
            end
            log_addr[log_count]  = mem_cmd.addr;
            log_write[log_count] = mem_cmd.write;
            log_count++;
            mem_ack = 1'b1;
         end else begin
            delay--;
         end
      end
   end

endmodule

`default_nettype wire

/* bench/tb_blast_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_blast_top import blast_pkg::*; ();

   localparam int MAX_LEN = 120;
   localparam int TIMEOUT = 5000;

   logic       clk;
   logic       reset;
   logic       app_ready;
   logic [7:0] app_code;
   logic       busy;
   logic       mem_req;
   mem_cmd_t   mem_cmd;
   logic       mem_ack;
   mem_word_u  mem_rdata;

   integer seed;

   // reference copies of the sequences
   logic [CHAR_BITS-1:0] query_ref   [0:QUERY_CHARS-1];
   logic [CHAR_BITS-1:0] subject_ref [0:MAX_LEN+CHARS_PER_WORD-1];
   hit_t                 exp_hits    [$];

   // port state one edge back
   logic     prev_req;
   logic     prev_ack;
   mem_cmd_t prev_cmd;

   blast_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .app_ready (app_ready),
      .app_code  (app_code),
      .busy      (busy),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   blast_memory_model u_mem (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   always #5 clk = ~clk;

   task automatic report_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic error_stop(input string msg);
      $display("error at %0t: %s", $time, msg);
      report_failure();
   endtask

   task automatic check_addr(input logic [ADDR_BITS-1:0] got, input logic [ADDR_BITS-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
         report_failure();
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
         report_failure();
      end
   endtask

   task automatic check_hit(input hit_t got, input hit_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got subject %0d query %0d, expected %0d %0d", $time,
                  what, got.subject_pos, got.query_pos, exp.subject_pos, exp.query_pos);
         report_failure();
      end
   endtask

   task automatic check_header(input header_t got, input header_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got id %h count %0d, expected id %h count %0d", $time,
                  what, got.subject_id, got.count, exp.subject_id, exp.count);
         report_failure();
      end
   endtask

   task automatic check_word(input mem_word_u got, input mem_word_u exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h, expected %h", $time, what, got.raw, exp.raw);
         report_failure();
      end
   endtask

   // four-phase rules seen from the memory side
   always @(posedge clk) begin
      if (reset) begin
         prev_req <= 1'b0;
         prev_ack <= 1'b0;
         prev_cmd <= '0;
      end else begin
         if (mem_req && !prev_req && prev_ack) begin
            error_stop("mem_req rose while mem_ack was still high");
         end
         if (!mem_req && prev_req && !prev_ack) begin
            error_stop("mem_req dropped before mem_ack was seen");
         end
         if (mem_req && prev_req) begin
            check_addr(mem_cmd.addr, prev_cmd.addr, "address during a request");
            check_word(mem_cmd.wdata, prev_cmd.wdata, "write data during a request");
            if (mem_cmd.write !== prev_cmd.write) begin
               error_stop("write flag changed during a request");
            end
         end
         prev_req <= mem_req;
         prev_ack <= mem_ack;
         prev_cmd <= mem_cmd;
      end
   end

   function automatic logic [CHAR_BITS-1:0] random_char();
      // mostly the four bases so that seeds repeat
      if ({$random(seed)} % 8 == 0) begin
         return CHAR_BITS'({$random(seed)} % 8);
      end
      return CHAR_BITS'({$random(seed)} % 4);
   endfunction

   task automatic wait_busy(input logic level);
      int n;
      n = 0;
      while (busy !== level) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            error_stop("timeout waiting for busy to change");
         end
      end
   endtask

   task automatic check_idle(input int cycles, input string what);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         if (busy || mem_req) begin
            error_stop(what);
         end
      end
   endtask

   task automatic issue_command(input logic [7:0] code);
      @(negedge clk);
      app_ready = 1'b1;
      app_code  = code;
      @(negedge clk);
      app_ready = 1'b0;
      app_code  = '0;
   endtask

   // lowest query position for every subject seed
   task automatic compute_hits(input int len);
      hit_t h;
      logic same;
      logic found;
      exp_hits.delete();
      for (int p = 0; p + SEED_LEN <= len; p++) begin
         found = 1'b0;
         for (int j = 0; j < SEED_POSITIONS && !found; j++) begin
            same = 1'b1;
            for (int k = 0; k < SEED_LEN; k++) begin
               if (query_ref[j+k] != subject_ref[p+k]) begin
                  same = 1'b0;
               end
            end
            if (same) begin
               found         = 1'b1;
               h.subject_pos = p;
               h.query_pos   = j;
               exp_hits.push_back(h);
            end
         end
      end
   endtask

   task automatic run_query();
      logic [WORD_BITS-1:0] word;
      int start;
      for (int i = 0; i < QUERY_CHARS; i++) begin
         query_ref[i] = random_char();
      end
      for (int w = 0; w < QUERY_WORDS; w++) begin
         word = '0;
         for (int i = 0; i < CHARS_PER_WORD; i++) begin
            word[i*CHAR_BITS +: CHAR_BITS] = query_ref[w*CHARS_PER_WORD + i];
         end
         u_mem.mem[QUERY_BASE + w] = word;
      end
      start = u_mem.log_count;
      issue_command(CMD_READ_QUERY);
      wait_busy(1'b1);
      wait_busy(1'b0);
      check_count(u_mem.log_count - start, QUERY_WORDS, "query accesses");
      for (int w = 0; w < QUERY_WORDS; w++) begin
         check_addr(u_mem.log_addr[start + w], QUERY_BASE + w, "query read address");
         if (u_mem.log_write[start + w]) begin
            error_stop("write seen during a query load");
         end
      end
   endtask

   task automatic run_subject(input int len);
      logic [WORD_BITS-1:0] word;
      header_t   hdr;
      header_t   sum;
      mem_word_u entry;
      int        start;
      int        last;
      int        n_words;
      int        n_reads;
      int        n_hits;
      hdr.subject_id = $random(seed);
      hdr.count      = len;
      n_words        = (len + CHARS_PER_WORD - 1) / CHARS_PER_WORD;
      // characters past the length are noise in the last word
      for (int i = 0; i < n_words * CHARS_PER_WORD; i++) begin
         subject_ref[i] = random_char();
      end
      u_mem.mem[SUBJECT_BASE] = hdr;
      for (int w = 0; w < n_words; w++) begin
         word = '0;
         for (int i = 0; i < CHARS_PER_WORD; i++) begin
            word[i*CHAR_BITS +: CHAR_BITS] = subject_ref[w*CHARS_PER_WORD + i];
         end
         u_mem.mem[SUBJECT_BASE + 1 + w] = word;
      end
      compute_hits(len);
      start = u_mem.log_count;
      issue_command(CMD_READ_SUBJECT);
      wait_busy(1'b1);
      wait_busy(1'b0);
      last = u_mem.log_count - 1;
      check_count(last + 1 - start, n_words + 2 + exp_hits.size(), "subject accesses");
      n_reads = 0;
      n_hits  = 0;
      for (int i = start; i < last; i++) begin
         entry = u_mem.log_data[i];
         if (u_mem.log_write[i]) begin
            if (n_hits >= exp_hits.size()) begin
               error_stop("more hit writes than the model expects");
            end
            check_addr(u_mem.log_addr[i], HIT_BASE + 1 + n_hits, "hit write address");
            check_hit(entry.hit, exp_hits[n_hits], "hit record");
            n_hits++;
         end else begin
            check_addr(u_mem.log_addr[i], SUBJECT_BASE + n_reads, "subject read address");
            n_reads++;
         end
      end
      check_count(n_reads, n_words + 1, "subject reads");
      // summary closes the command
      if (!u_mem.log_write[last]) begin
         error_stop("last access of a subject is not the summary write");
      end
      check_addr(u_mem.log_addr[last], HIT_BASE, "summary address");
      sum.subject_id = hdr.subject_id;
      sum.count      = exp_hits.size();
      entry          = u_mem.log_data[last];
      check_header(entry.header, sum, "summary word");
      check_idle(4, "activity after the summary write");
   endtask

   initial begin
      seed      = 85;
      clk       = 1'b0;
      reset     = 1'b1;
      app_ready = 1'b0;
      app_code  = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;

      check_idle(8, "busy or mem_req active before any command");
      issue_command(8'h5c);
      check_idle(8, "an unknown command code started work");
      check_count(u_mem.log_count, 0, "accesses before a valid command");

      run_query();
      // short and odd lengths first
      for (int len = 0; len <= SEED_LEN; len++) begin
         run_subject(len);
      end
      run_subject(21);
      run_subject(25);
      run_subject(42);
      run_subject(63);
      for (int t = 0; t < 12; t++) begin
         run_subject({$random(seed)} % MAX_LEN);
      end
      // a fresh query changes every expected hit
      run_query();
      for (int t = 0; t < 6; t++) begin
         run_subject({$random(seed)} % MAX_LEN);
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
source/blast_pkg.sv
source/query_buffer.sv
source/subject_shifter.sv
source/seed_matcher.sv
source/blast_sequencer.sv
source/blast_top.sv
bench/blast_memory_model.sv
bench/tb_blast_top.sv

/* Bender.yml */
package:
  name: blast_front_end

sources:
  - files:
      - source/blast_pkg.sv
      - source/query_buffer.sv
      - source/subject_shifter.sv
      - source/seed_matcher.sv
      - source/blast_sequencer.sv
      - source/blast_top.sv
  - target: test
    files:
      - bench/blast_memory_model.sv
      - bench/tb_blast_top.sv
